// File: tests/sa_trace.txt
// one test per line, hex words in this order
// mode  row_start  burst_len  row_in  column_in  expected lanes of element (3,3)
// mode 0 lanes {16'h0, L*p1*w, L*p0*w}, mode 1 lanes {L*p1*w1, L*p0*w1, L*p1*w0, L*p0*w0}
// a mode word of f ends the list

// mode 0, negative weights, full array
0 0 3 80ff7f03 ff800102a5c310fe 0000fe8180ff4000
0 2 5 f60a817f 7b2c0000ffff0901 0000ffe7fafff768
0 1 8 7f8001ff ffff0000800100ff 000003f40803f408
0 0 1 0140c081 0102ffee33000080 0000000001000002

// everything masked
0 4 6 11223344 0102030405060708 0000000000000000

// mode 1, binary weights
1 0 4 02010300 64c80a14ff013377 fe70fce001900320
1 3 2 03000201 ffff123456789abc fe02fe02fe02fe02
1 1 7 01020300 800755aa0000ffff 03800031fc80ffcf

f 0 0 0 0 0

// File: flist.f
rtl/sa_pkg.sv
rtl/operand_pack.sv
rtl/pe_sum_e.sv
rtl/quan_sa_sum_e.sv
rtl/row_readout.sv
rtl/sa_top.sv
tests/tb_sa_top.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_sa_top -f flist.f -o tb_sa_top

./obj_dir/tb_sa_top > sim.log 2>&1 || true
cat sim.log

if grep -qx "TB PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: tests/tb_sa_top.sv
module tb_sa_top import sa_pkg::*; ();

    localparam int ROWS          = 4;
    localparam int COLS          = 4;
    localparam int OUT_W         = COLS * PE_OUT_W;
    localparam int HALF_18       = COLS * 2 * LANE_W_18;
    localparam int FIELDS        = 6;               // words per trace test
    localparam int TRACE_DEPTH   = FIELDS * 32;
    localparam int NUM_RANDOM    = 8;
    localparam int NUM_MULT      = 6;
    localparam int TEST_OVERHEAD = 6 * ROWS + 20;   // cycles per test without the burst

    logic                         clk = 1'b0;
    logic                         reset;
    logic [MODE_W-1:0]            mode_init;
    logic [ROWS*WEIGHT_W-1:0]     row_in;
    logic [COLS*PIXEL_PAIR_W-1:0] column_in;
    logic                         en;
    logic [ROW_START_W-1:0]       row_start;
    logic                         clear;
    logic                         mult_array_mode;
    logic [COLS*MULT_A_W-1:0]     sa_sum_in;
    logic [COLS*MULT_B_W-1:0]     sa_e_in;
    logic                         channel_out_reset;
    logic                         channel_out_en;
    logic [OUT_W-1:0]             out;
    logic [COLS*MULT_P_W-1:0]     row0_out;

    logic [63:0] trace_mem [TRACE_DEPTH];
    logic [63:0] rng_state     = 64'd82384;
    longint      budget_cycles = 0;

    sa_top #(.ROWS(ROWS), .COLS(COLS)) i_sa_top (
        .clk               (clk),
        .reset             (reset),
        .mode_init         (mode_init),
        .row_in            (row_in),
        .column_in         (column_in),
        .en                (en),
        .row_start         (row_start),
        .clear             (clear),
        .mult_array_mode   (mult_array_mode),
        .sa_sum_in         (sa_sum_in),
        .sa_e_in           (sa_e_in),
        .channel_out_reset (channel_out_reset),
        .channel_out_en    (channel_out_en),
        .out               (out),
        .row0_out          (row0_out)
    );

    always #50 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // helpers

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        return rng_state[63:32];                   // high half since low bits cycle too fast
    endfunction

    task automatic check_value(
        input string            name,
        input logic [OUT_W-1:0] got,
        input logic [OUT_W-1:0] want
    );
        if (got !== want) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, want);
            $display("TB FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // lane sums of element (i,j) after a burst of len cycles
    function automatic logic [PE_OUT_W-1:0] expected_pe(
        input logic [MODE_W-1:0]       mode,
        input int                      rs,
        input int                      len,
        input logic [WEIGHT_W-1:0]     w,
        input logic [PIXEL_PAIR_W-1:0] pair,
        input int                      i,
        input int                      j
    );
        logic [PE_OUT_W-1:0] pe;
        int                  p0;
        int                  p1;
        int                  w0;
        int                  w1;
        pe = '0;
        p0 = int'(pair[PIXEL_W-1:0]);
        p1 = int'(pair[PIXEL_PAIR_W-1:PIXEL_W]);
        if (i >= rs && j >= rs) begin               // masked elements stay zero
            if (mode == MODE_88) begin
                w0 = int'($signed(w));
                pe[0 +: LANE_W_88]         = LANE_W_88'(len * p0 * w0);
                pe[LANE_W_88 +: LANE_W_88] = LANE_W_88'(len * p1 * w0);
            end else begin
                w0 = w[0] ? -1 : 1;                 // bit set means -1
                w1 = w[1] ? -1 : 1;
                pe[0 +: LANE_W_18]           = LANE_W_18'(len * p0 * w0);
                pe[LANE_W_18 +: LANE_W_18]   = LANE_W_18'(len * p1 * w0);
                pe[2*LANE_W_18 +: LANE_W_18] = LANE_W_18'(len * p0 * w1);
                pe[3*LANE_W_18 +: LANE_W_18] = LANE_W_18'(len * p1 * w1);
            end
        end
        return pe;
    endfunction

    function automatic logic [OUT_W-1:0] expected_row(
        input logic [MODE_W-1:0]            mode,
        input int                           rs,
        input int                           len,
        input logic [ROWS*WEIGHT_W-1:0]     rin,
        input logic [COLS*PIXEL_PAIR_W-1:0] cin,
        input int                           r
    );
        logic [OUT_W-1:0]    row;
        logic [PE_OUT_W-1:0] pe;
        row = '0;
        for (int j = 0; j < COLS; j++) begin
            pe = expected_pe(mode, rs, len, rin[r*WEIGHT_W +: WEIGHT_W],
                             cin[j*PIXEL_PAIR_W +: PIXEL_PAIR_W], r, j);
            if (mode == MODE_88) begin
                row[j*2*LANE_W_88 +: 2*LANE_W_88] = pe[0 +: 2*LANE_W_88];
            end else begin
                // lanes 0 and 1 of every column first, lanes 2 and 3 after them
                row[j*2*LANE_W_18 +: 2*LANE_W_18]           = pe[0 +: 2*LANE_W_18];
                row[HALF_18 + j*2*LANE_W_18 +: 2*LANE_W_18] = pe[2*LANE_W_18 +: 2*LANE_W_18];
            end
        end
        return row;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reset, throwaway burst, clear, real burst and readout of one test

    task automatic run_test(
        input logic [MODE_W-1:0]            mode,
        input int                           rs,
        input int                           len,
        input logic [ROWS*WEIGHT_W-1:0]     rin,
        input logic [COLS*PIXEL_PAIR_W-1:0] cin,
        input logic                         has_corner,
        input logic [PE_OUT_W-1:0]          corner
    );
        logic [PE_OUT_W-1:0] got_pe;
        @(posedge clk);
        reset             <= 1'b1;          // mode only loads here
        channel_out_reset <= 1'b1;
        mode_init         <= mode;
        row_start         <= '0;
        row_in            <= next_rand();
        column_in         <= {next_rand(), next_rand()};
        repeat (5) @(posedge clk);
        reset             <= 1'b0;
        channel_out_reset <= 1'b0;
        repeat (2 * ROWS) @(posedge clk);
        en <= 1'b1;
        repeat (3) @(posedge clk);
        en <= 1'b0;
        repeat (2) @(posedge clk);
        clear <= 1'b1;                      // wipes the throwaway sums
        @(posedge clk);
        clear     <= 1'b0;
        row_in    <= rin;
        column_in <= cin;
        row_start <= ROW_START_W'(rs);
        repeat (2 * ROWS) @(posedge clk);   // operands settle through the grid
        en <= 1'b1;
        repeat (len) @(posedge clk);
        en <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("out", out, '0);        // strobe still low
        @(posedge clk);
        channel_out_en <= 1'b1;
        for (int r = 0; r <= ROWS; r++) begin   // last pass checks the wrap to row 0
            @(negedge clk);
            check_value("out", out, expected_row(mode, rs, len, rin, cin, r % ROWS));
            if (r == ROWS - 1 && has_corner) begin
                if (mode == MODE_88) begin
                    got_pe = PE_OUT_W'(out[(COLS-1)*2*LANE_W_88 +: 2*LANE_W_88]);
                end else begin
                    got_pe = {out[HALF_18 + (COLS-1)*2*LANE_W_18 +: 2*LANE_W_18],
                              out[(COLS-1)*2*LANE_W_18 +: 2*LANE_W_18]};
                end
                check_value("corner lanes", OUT_W'(got_pe), OUT_W'(corner));
            end
            @(posedge clk);
        end
        channel_out_en <= 1'b0;             // counter left at row 1
    endtask

    task automatic check_multiplier();
        logic signed [MULT_A_W-1:0] a;
        logic signed [MULT_B_W-1:0] b;
        logic signed [MULT_P_W-1:0] p;
        logic [COLS*MULT_A_W-1:0]   sums;
        logic [COLS*MULT_B_W-1:0]   scales;
        logic [COLS*MULT_P_W-1:0]   want;
        for (int n = 0; n < NUM_MULT; n++) begin
            for (int j = 0; j < COLS; j++) begin
                sums[j*MULT_A_W +: MULT_A_W]   = MULT_A_W'(next_rand());
                scales[j*MULT_B_W +: MULT_B_W] = MULT_B_W'(next_rand());
                a = sums[j*MULT_A_W +: MULT_A_W];
                b = scales[j*MULT_B_W +: MULT_B_W];
                p = a * b;
                want[j*MULT_P_W +: MULT_P_W] = p;
            end
            @(posedge clk);
            mult_array_mode <= 1'b1;
            sa_sum_in       <= sums;
            sa_e_in         <= scales;
            @(posedge clk);                 // product registered here
            @(negedge clk);
            check_value("row0_out", OUT_W'(row0_out), OUT_W'(want));
        end
        @(posedge clk);
        mult_array_mode <= 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value("row0_out held", OUT_W'(row0_out), OUT_W'(want));
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence and watchdog

    initial begin
        logic [MODE_W-1:0] mode;
        int                base;
        int                rs;
        int                len;
        int                num_trace;
        longint            cycles;
        reset             <= 1'b1;
        mode_init         <= '0;
        row_in            <= '0;
        column_in         <= '0;
        en                <= 1'b0;
        row_start         <= '0;
        clear             <= 1'b0;
        mult_array_mode   <= 1'b0;
        sa_sum_in         <= '0;
        sa_e_in           <= '0;
        channel_out_reset <= 1'b1;
        channel_out_en    <= 1'b0;
        $readmemh("tests/sa_trace.txt", trace_mem);
        num_trace = 0;
        while (num_trace < TRACE_DEPTH / FIELDS && trace_mem[num_trace * FIELDS] != 64'hf) begin
            num_trace++;
        end
        if (num_trace == 0) begin
            $display("trace file tests/sa_trace.txt holds no tests");
            $display("TB FAILED");
            $fatal(1, "empty trace");
        end
        cycles = 5 + 2 * NUM_MULT + 8 + NUM_RANDOM * (TEST_OVERHEAD + 8);
        for (int t = 0; t < num_trace; t++) begin
            cycles += TEST_OVERHEAD + longint'(trace_mem[t * FIELDS + 2]);
        end
        budget_cycles = 2 * cycles;
        repeat (5) @(posedge clk);
        reset             <= 1'b0;
        channel_out_reset <= 1'b0;
        for (int t = 0; t < num_trace; t++) begin
            base = t * FIELDS;
            run_test(trace_mem[base][MODE_W-1:0], int'(trace_mem[base + 1]),
                     int'(trace_mem[base + 2]), trace_mem[base + 3][ROWS*WEIGHT_W-1:0],
                     trace_mem[base + 4][COLS*PIXEL_PAIR_W-1:0], 1'b1, trace_mem[base + 5]);
        end
        for (int n = 0; n < NUM_RANDOM; n++) begin
            mode = MODE_W'(next_rand() % 2);
            rs   = int'(next_rand() % (ROWS + 1));
            len  = 1 + int'(next_rand() % 8);
            run_test(mode, rs, len, next_rand(), {next_rand(), next_rand()}, 1'b0, '0);
        end
        check_multiplier();
        $display("TB PASSED");
        $finish;
    end

    initial begin
        wait (budget_cycles != 0);
        repeat (budget_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles before the tests finished", budget_cycles);
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

endmodule

// File: rtl/sa_top.sv
module sa_top import sa_pkg::*; #(
    parameter int ROWS = 16,
    parameter int COLS = 16
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [MODE_W-1:0]            mode_init,
    input  logic [ROWS*WEIGHT_W-1:0]     row_in,
    input  logic [COLS*PIXEL_PAIR_W-1:0] column_in,
    input  logic                         en,
    input  logic [ROW_START_W-1:0]       row_start,
    input  logic                         clear,
    input  logic                         mult_array_mode,
    input  logic [COLS*MULT_A_W-1:0]     sa_sum_in,
    input  logic [COLS*MULT_B_W-1:0]     sa_e_in,
    input  logic                         channel_out_reset,
    input  logic                         channel_out_en,
    output logic [COLS*PE_OUT_W-1:0]     out,
    output logic [COLS*MULT_P_W-1:0]     row0_out
);

    logic [MODE_W-1:0]             mode;
    logic [ROWS*OPERAND_W-1:0]     weight_ops;
    logic [COLS*OPERAND_W-1:0]     pixel_ops;
    logic [ROWS*COLS*PE_OUT_W-1:0] pe_outs;

    operand_pack #(.ROWS(ROWS), .COLS(COLS)) i_operand_pack (
        .mode       (mode),
        .row_in     (row_in),
        .column_in  (column_in),
        .weight_ops (weight_ops),
        .pixel_ops  (pixel_ops)
    );

    quan_sa_sum_e #(.ROWS(ROWS), .COLS(COLS)) i_array (
        .clk             (clk),
        .reset           (reset),
        .mode_init       (mode_init),
        .en              (en),
        .row_start       (row_start),
        .clear           (clear),
        .weight_ops      (weight_ops),
        .pixel_ops       (pixel_ops),
        .mult_array_mode (mult_array_mode),
        .sa_sum_in       (sa_sum_in),
        .sa_e_in         (sa_e_in),
        .mode            (mode),
        .pe_outs         (pe_outs),
        .row0_out        (row0_out)
    );

    row_readout #(.ROWS(ROWS), .COLS(COLS)) i_readout (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .channel_out_en    (channel_out_en),
        .mode              (mode),
        .pe_outs           (pe_outs),
        .out               (out)
    );

endmodule

// File: rtl/row_readout.sv
module row_readout import sa_pkg::*; #(
    parameter int ROWS = 16,
    parameter int COLS = 16
) (
    input  logic                          clk,
    input  logic                          channel_out_reset,
    input  logic                          channel_out_en,
    input  logic [MODE_W-1:0]             mode,
    input  logic [ROWS*COLS*PE_OUT_W-1:0] pe_outs,
    output logic [COLS*PE_OUT_W-1:0]      out
);

    localparam int CNT_W   = $clog2(ROWS + 1);
    localparam int ROW_W   = COLS * PE_OUT_W;
    localparam int PAIR_88 = 2 * LANE_W_88;
    localparam int PAIR_18 = 2 * LANE_W_18;
    localparam int HALF_18 = COLS * PAIR_18;     // lanes 2-3 start here

    logic [CNT_W-1:0]        row_counter;
    logic [ROW_W-1:0]        row_sel;
    logic [COLS*PAIR_88-1:0] lanes_88;
    logic [ROW_W-1:0]        lanes_18;

    // one row per strobe, wraps after the last row
    always_ff @(posedge clk) begin
        if (channel_out_reset) begin
            row_counter <= '0;
        end else if (channel_out_en) begin
            if (row_counter == CNT_W'(ROWS - 1)) begin
                row_counter <= '0;
            end else begin
                row_counter <= row_counter + 1'b1;
            end
        end
    end

    assign row_sel = pe_outs[row_counter * ROW_W +: ROW_W];

    //////////////////////////////////////////////////////////////////////
    // lane assembly

    for (genvar j = 0; j < COLS; j++) begin : g_col
        assign lanes_88[j*PAIR_88 +: PAIR_88] = row_sel[j*PE_OUT_W +: PAIR_88];
        assign lanes_18[j*PAIR_18 +: PAIR_18] = row_sel[j*PE_OUT_W +: PAIR_18];
        assign lanes_18[HALF_18 + j*PAIR_18 +: PAIR_18] =
            row_sel[j*PE_OUT_W + PAIR_18 +: PAIR_18];
    end

    always_comb begin
        out = '0;
        if (channel_out_en) begin
            case (mode)
                MODE_88: out = ROW_W'(lanes_88);    // top bits left zero
                MODE_18: out = lanes_18;
                default: out = '0;
            endcase
        end
    end

    a_row_in_range: assert property (
        @(posedge clk) channel_out_en |-> (row_counter < ROWS)
    );

endmodule

// File: rtl/quan_sa_sum_e.sv
module quan_sa_sum_e import sa_pkg::*; #(
    parameter int ROWS = 16,
    parameter int COLS = 16
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [MODE_W-1:0]             mode_init,
    input  logic                          en,
    input  logic [ROW_START_W-1:0]        row_start,
    input  logic                          clear,
    input  logic [ROWS*OPERAND_W-1:0]     weight_ops,
    input  logic [COLS*OPERAND_W-1:0]     pixel_ops,
    input  logic                          mult_array_mode,
    input  logic [COLS*MULT_A_W-1:0]      sa_sum_in,
    input  logic [COLS*MULT_B_W-1:0]      sa_e_in,
    output logic [MODE_W-1:0]             mode,
    output logic [ROWS*COLS*PE_OUT_W-1:0] pe_outs,
    output logic [COLS*MULT_P_W-1:0]      row0_out
);

    logic                     en_q;
    logic [ROW_START_W-1:0]   row_start_q;
    logic                     mult_mode_q;
    logic [ROWS-1:0]          row_on;
    logic [COLS-1:0]          col_on;
    logic [COLS*MULT_P_W-1:0] row0_mult;
    logic [COLS*MULT_P_W-1:0] row0_hold;

    logic [OPERAND_W-1:0] up     [ROWS][COLS];
    logic [OPERAND_W-1:0] left   [ROWS][COLS];
    logic [OPERAND_W-1:0] bottom [ROWS][COLS];
    logic [OPERAND_W-1:0] right  [ROWS][COLS];
    logic [MULT_P_W-1:0]  mult   [ROWS][COLS];

    // mode only loads during reset
    always_ff @(posedge clk) begin
        if (reset) begin
            mode <= mode_init;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            en_q        <= 1'b0;
            row_start_q <= '0;
            mult_mode_q <= 1'b0;
        end else begin
            en_q        <= en;
            row_start_q <= row_start;
            mult_mode_q <= mult_array_mode;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // enable mask, leading rows and columns switched off by row_start

    for (genvar i = 0; i < ROWS; i++) begin : g_row_on
        assign row_on[i] = en_q && (row_start_q <= ROW_START_W'(i));
    end

    for (genvar j = 0; j < COLS; j++) begin : g_col_on
        assign col_on[j] = en_q && (row_start_q <= ROW_START_W'(j));
    end

    //////////////////////////////////////////////////////////////////////
    // PE grid

    for (genvar i = 0; i < ROWS; i++) begin : g_row
        for (genvar j = 0; j < COLS; j++) begin : g_col
            logic [OPERAND_W-1:0] up_feed;
            logic [OPERAND_W-1:0] left_feed;
            logic                 pe_en;

            if (i == 0) begin : g_up_edge
                assign up_feed = pixel_ops[j*OPERAND_W +: OPERAND_W];
            end else begin : g_up_chain
                assign up_feed = bottom[i-1][j];
            end

            if (j == 0) begin : g_left_edge
                assign left_feed = weight_ops[i*OPERAND_W +: OPERAND_W];
            end else begin : g_left_chain
                assign left_feed = right[i][j-1];
            end

            if (i == 0) begin : g_mult_row
                logic [MULT_A_W-1:0] sum_in;
                logic [MULT_B_W-1:0] e_in;

                assign sum_in = sa_sum_in[j*MULT_A_W +: MULT_A_W];
                assign e_in   = sa_e_in[j*MULT_B_W +: MULT_B_W];

                // multiplier mode takes over row 0 and keeps it running
                assign up[i][j] = mult_array_mode ?
                    {{(OPERAND_W-MULT_A_W){sum_in[MULT_A_W-1]}}, sum_in} : up_feed;
                assign left[i][j] = mult_array_mode ?
                    {{(OPERAND_W-MULT_B_W){e_in[MULT_B_W-1]}}, e_in} : left_feed;
                assign pe_en = mult_array_mode || (row_on[i] && col_on[j]);

                assign row0_mult[j*MULT_P_W +: MULT_P_W] = mult[i][j];
            end else begin : g_plain_row
                assign up[i][j]   = up_feed;
                assign left[i][j] = left_feed;
                assign pe_en      = row_on[i] && col_on[j];
            end

            pe_sum_e i_pe (
                .clk      (clk),
                .reset    (reset),
                .mode     (mode),
                .en       (pe_en),
                .clear    (clear),
                .up       (up[i][j]),
                .left     (left[i][j]),
                .bottom   (bottom[i][j]),
                .right    (right[i][j]),
                .mult_out (mult[i][j]),
                .out      (pe_outs[(i*COLS+j)*PE_OUT_W +: PE_OUT_W])
            );
        end
    end

    // row 0 products pass straight through while in multiplier mode,
    // otherwise the last one is held
    always_ff @(posedge clk) begin
        if (mult_mode_q) begin
            row0_hold <= row0_mult;
        end
    end

    assign row0_out = mult_mode_q ? row0_mult : row0_hold;

    a_row_start_range: assert property (
        @(posedge clk) disable iff (reset)
        row_start_q <= ROW_START_W'(ROWS)
    );

endmodule

// File: rtl/pe_sum_e.sv
module pe_sum_e import sa_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [MODE_W-1:0]    mode,
    input  logic                 en,
    input  logic                 clear,
    input  logic [OPERAND_W-1:0] up,
    input  logic [OPERAND_W-1:0] left,
    output logic [OPERAND_W-1:0] bottom,
    output logic [OPERAND_W-1:0] right,
    output logic [MULT_P_W-1:0]  mult_out,
    output logic [PE_OUT_W-1:0]  out
);

    logic signed [PROD_W-1:0] prod;         // packed lanes of forwarded operands
    logic signed [PROD_W-1:0] mult_full;    // plain product, row 0 only
    logic [PE_OUT_W-1:0]      lanes;
    logic [PE_OUT_W-1:0]      acc;
    logic [PE_OUT_W-1:0]      acc_next;

    //////////////////////////////////////////////////////////////////////
    // operand forwarding

    always_ff @(posedge clk) begin
        bottom   <= up;
        right    <= left;
        mult_out <= mult_full[MULT_P_W-1:0];
    end

    assign prod      = $signed(bottom) * $signed(right);
    assign mult_full = $signed(up) * $signed(left);

    //////////////////////////////////////////////////////////////////////
    // packed MAC, lanes summed separately so headroom never spills over

    assign lanes = (mode == MODE_18) ? unpack_18(prod) : unpack_88(prod);

    always_comb begin
        acc_next = acc;
        if (mode == MODE_88) begin
            for (int k = 0; k < LANES_88; k++) begin
                acc_next[k*LANE_W_88 +: LANE_W_88] =
                    acc[k*LANE_W_88 +: LANE_W_88] + lanes[k*LANE_W_88 +: LANE_W_88];
            end
        end else if (mode == MODE_18) begin
            for (int k = 0; k < LANES_18; k++) begin
                acc_next[k*LANE_W_18 +: LANE_W_18] =
                    acc[k*LANE_W_18 +: LANE_W_18] + lanes[k*LANE_W_18 +: LANE_W_18];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            acc <= '0;              // clear wins over en
        end else if (en) begin
            acc <= acc_next;
        end
    end

    // mode 0: {16'b0, p1*w, p0*w}
    // mode 1: {p1*w1, p0*w1, p1*w0, p0*w0}
    assign out = acc;

    // an undefined mode packs zero operands, so accumulating there is a
    // sequencing fault upstream
    a_mode_valid: assert property (
        @(posedge clk) disable iff (reset)
        en |-> (mode == MODE_88 || mode == MODE_18)
    );

endmodule

// File: rtl/operand_pack.sv
module operand_pack import sa_pkg::*; #(
    parameter int ROWS = 16,
    parameter int COLS = 16
) (
    input  logic [MODE_W-1:0]            mode,
    input  logic [ROWS*WEIGHT_W-1:0]     row_in,
    input  logic [COLS*PIXEL_PAIR_W-1:0] column_in,
    output logic [ROWS*OPERAND_W-1:0]    weight_ops,
    output logic [COLS*OPERAND_W-1:0]    pixel_ops
);

    localparam logic [OPERAND_W-1:0] PLUS_ONE  = OPERAND_W'(1);
    localparam logic [OPERAND_W-1:0] MINUS_ONE = '1;

    //////////////////////////////////////////////////////////////////////
    // pixel side, high pixel sits one lane step above the low pixel

    for (genvar j = 0; j < COLS; j++) begin : g_pixel
        logic [PIXEL_W-1:0] p_lo;
        logic [PIXEL_W-1:0] p_hi;

        assign p_lo = column_in[j*PIXEL_PAIR_W +: PIXEL_W];
        assign p_hi = column_in[j*PIXEL_PAIR_W + PIXEL_W +: PIXEL_W];

        assign pixel_ops[j*OPERAND_W +: OPERAND_W] =
            (mode == MODE_88) ? ((OPERAND_W'(p_hi) << LANE_STEP_88) | OPERAND_W'(p_lo)) :
            (mode == MODE_18) ? ((OPERAND_W'(p_hi) << LANE_STEP_18) | OPERAND_W'(p_lo)) :
            '0;
    end

    //////////////////////////////////////////////////////////////////////
    // weight side

    for (genvar i = 0; i < ROWS; i++) begin : g_weight
        logic [WEIGHT_W-1:0]  w;
        logic [OPERAND_W-1:0] w_lo;     // +-1 at bit 0
        logic [OPERAND_W-1:0] w_hi;     // +-1 two lane steps up

        assign w = row_in[i*WEIGHT_W +: WEIGHT_W];

        // bit set means -1
        assign w_lo = w[0] ? MINUS_ONE : PLUS_ONE;
        assign w_hi = (w[1] ? MINUS_ONE : PLUS_ONE) << (2 * LANE_STEP_18);

        assign weight_ops[i*OPERAND_W +: OPERAND_W] =
            (mode == MODE_88) ? {{(OPERAND_W-WEIGHT_W){w[WEIGHT_W-1]}}, w} :
            (mode == MODE_18) ? (w_hi + w_lo) :
            '0;
    end

endmodule

// File: rtl/sa_pkg.sv
package sa_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths

    localparam int OPERAND_W    = 25;               // wide multiplier port
    localparam int PROD_W       = 2 * OPERAND_W;
    localparam int PIXEL_W      = 8;
    localparam int PIXEL_PAIR_W = 2 * PIXEL_W;      // two pixels per column
    localparam int WEIGHT_W     = 8;                // mode 1 uses bits 1:0
    localparam int LANE_W_88    = 24;               // 16 + 8 headroom
    localparam int LANE_W_18    = 16;               // 8 + 8 headroom
    localparam int PE_OUT_W     = 64;               // four mode 1 lanes
    localparam int ROW_START_W  = 6;

    // lane spacing inside the packed product
    localparam int LANES_88     = 2;
    localparam int LANE_STEP_88 = 16;
    localparam int LANES_18     = 4;
    localparam int LANE_STEP_18 = 9;

    // row 0 as plain multiplier
    localparam int MULT_A_W = 24;
    localparam int MULT_B_W = 16;
    localparam int MULT_P_W = 40;

    localparam int MODE_W = 4;
    localparam logic [MODE_W-1:0] MODE_88 = 4'd0;   // u8 pixels x s8 weight
    localparam logic [MODE_W-1:0] MODE_18 = 4'd1;   // u8 pixels x binary weights

    //////////////////////////////////////////////////////////////////////
    // lane unpacking, each lane takes the borrow of the signed lane below

    function automatic logic [PE_OUT_W-1:0] unpack_88(input logic [PROD_W-1:0] prod);
        logic [LANE_STEP_88-1:0] field;
        logic                    borrow;
        logic [PE_OUT_W-1:0]     lanes;
        lanes  = '0;
        borrow = 1'b0;
        for (int k = 0; k < LANES_88; k++) begin
            field = prod[k*LANE_STEP_88 +: LANE_STEP_88];
            lanes[k*LANE_W_88 +: LANE_W_88] =
                {{(LANE_W_88-LANE_STEP_88){field[LANE_STEP_88-1]}}, field}
                + LANE_W_88'(borrow);
            borrow = field[LANE_STEP_88-1];
        end
        return lanes;
    endfunction

    function automatic logic [PE_OUT_W-1:0] unpack_18(input logic [PROD_W-1:0] prod);
        logic [LANE_STEP_18-1:0] field;
        logic                    borrow;
        logic [PE_OUT_W-1:0]     lanes;
        lanes  = '0;
        borrow = 1'b0;
        for (int k = 0; k < LANES_18; k++) begin
            field = prod[k*LANE_STEP_18 +: LANE_STEP_18];
            lanes[k*LANE_W_18 +: LANE_W_18] =
                {{(LANE_W_18-LANE_STEP_18){field[LANE_STEP_18-1]}}, field}
                + LANE_W_18'(borrow);
            borrow = field[LANE_STEP_18-1];
        end
        return lanes;
    endfunction

endpackage
